// File: gty_ctrl.f
hdl/gty_ctrl_pkg.sv
hdl/gty_reg_file.sv
hdl/gty_drp_bridge.sv
hdl/gty_tx_sync.sv
hdl/gty_rx_sync.sv
hdl/gty_ctrl.sv
verif/gty_ctrl_clk_gen.sv
verif/gty_ctrl_chk.sv
verif/gty_ctrl_tb.sv

// File: hdl/gty_ctrl.sv
// Transceiver lane control top.
// Splits host accesses between the local register file and the DRP
// bridge, and connects the TX and RX user clock domain logic.
`timescale 1ns/1ns
`default_nettype none

module gty_ctrl
    import gty_ctrl_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     gty_rx_reset_reg,

    input  wire bus_req_t bus_req_i,
    output bus_rsp_t      bus_rsp_o,

    output drp_req_t      drp_req_o,
    input  wire data_t    drp_di_i,
    input  wire logic     drp_rdy_i,

    output logic          gty_reset_o,
    output logic          gty_tx_reset_o,
    output logic          gty_rx_reset_o,
    input  wire logic     gty_tx_reset_done_i,
    input  wire logic     gty_rx_reset_done_i,

    input  wire logic     gty_txusrclk2_i,
    input  wire logic     gty_rxusrclk2_i,
    output tx_cfg_t       gty_tx_cfg_o,
    output rx_cfg_t       gty_rx_cfg_o,
    input  wire logic     gty_rxprbserr_i,
    input  wire logic     gty_rxprbslocked_i
);

    bus_req_t  reg_req;
    bus_req_t  drp_bus_req;
    bus_rsp_t  reg_rsp;
    bus_rsp_t  drp_rsp;
    lane_rst_t lane_rst;
    tx_cfg_t   tx_cfg;
    rx_cfg_t   rx_cfg;
    logic      tx_done;
    logic      rx_done;
    logic      prbs_err;
    logic      prbs_lock;
    logic      sel_local;

    assign sel_local = bus_req_i.adr[BUS_ADDR_W-1];

    always_comb begin
        reg_req         = bus_req_i;
        reg_req.stb     = bus_req_i.stb && sel_local;
        reg_req.cyc     = bus_req_i.cyc && sel_local;
        drp_bus_req     = bus_req_i;
        drp_bus_req.stb = bus_req_i.stb && !sel_local;
        drp_bus_req.cyc = bus_req_i.cyc && !sel_local;
    end

    // Idle side returns all zeros.
    assign bus_rsp_o   = reg_rsp | drp_rsp;
    assign gty_reset_o = lane_rst.lane;

    gty_reg_file u_reg_file (
        .clk              (clk),
        .gty_rx_reset_reg (gty_rx_reset_reg),
        .bus_req_i        (reg_req),
        .bus_rsp_o        (reg_rsp),
        .lane_rst_o       (lane_rst),
        .tx_cfg_o         (tx_cfg),
        .rx_cfg_o         (rx_cfg),
        .tx_done_i        (tx_done),
        .rx_done_i        (rx_done),
        .prbs_err_i       (prbs_err),
        .prbs_lock_i      (prbs_lock)
    );

    gty_drp_bridge u_drp_bridge (
        .clk              (clk),
        .gty_rx_reset_reg (gty_rx_reset_reg),
        .bus_req_i        (drp_bus_req),
        .bus_rsp_o        (drp_rsp),
        .drp_req_o        (drp_req_o),
        .drp_di_i         (drp_di_i),
        .drp_rdy_i        (drp_rdy_i)
    );

    gty_tx_sync u_tx_sync (
        .clk             (clk),
        .gty_txusrclk2_i (gty_txusrclk2_i),
        .tx_rst_req_i    (lane_rst.tx),
        .tx_cfg_i        (tx_cfg),
        .tx_cfg_o        (gty_tx_cfg_o),
        .tx_reset_o      (gty_tx_reset_o),
        .tx_reset_done_i (gty_tx_reset_done_i),
        .tx_done_o       (tx_done)
    );

    gty_rx_sync u_rx_sync (
        .clk             (clk),
        .gty_rxusrclk2_i (gty_rxusrclk2_i),
        .rx_rst_req_i    (lane_rst.rx),
        .rx_cfg_i        (rx_cfg),
        .rx_cfg_o        (gty_rx_cfg_o),
        .rx_reset_o      (gty_rx_reset_o),
        .rx_reset_done_i (gty_rx_reset_done_i),
        .prbserr_i       (gty_rxprbserr_i),
        .prbslocked_i    (gty_rxprbslocked_i),
        .rx_done_o       (rx_done),
        .prbs_err_o      (prbs_err),
        .prbs_lock_o     (prbs_lock)
    );

endmodule

`default_nettype wire

// File: hdl/gty_ctrl_pkg.sv
// Transceiver lane control package.
// Widths, local register map, reset defaults and the bus, DRP and
// per-domain configuration types shared by the lane control block.
`default_nettype none

package gty_ctrl_pkg;

    localparam int DRP_ADDR_W = 10;
    localparam int BUS_ADDR_W = DRP_ADDR_W + 1;  // Top bit selects local registers.
    localparam int DATA_W     = 16;

    typedef logic [DRP_ADDR_W-1:0] drp_addr_t;
    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [7:0]            reg_idx_t;

    typedef logic [3:0] prbs_sel_t;
    typedef logic [4:0] swing_t;
    typedef logic [4:0] cursor_t;
    typedef logic [6:0] main_cursor_t;

    // Local register map.
    localparam reg_idx_t REG_RESET     = 8'h00;
    localparam reg_idx_t REG_POLARITY  = 8'h01;
    localparam reg_idx_t REG_PRBS_SEL  = 8'h02;
    localparam reg_idx_t REG_PRBS_CTRL = 8'h03;
    localparam reg_idx_t REG_TX_IDLE   = 8'h04;
    localparam reg_idx_t REG_TX_DIFF   = 8'h05;
    localparam reg_idx_t REG_TX_MAIN   = 8'h06;
    localparam reg_idx_t REG_TX_POST   = 8'h07;
    localparam reg_idx_t REG_TX_PRE    = 8'h08;

    localparam swing_t       TX_DIFF_DEFAULT = 5'd16;
    localparam main_cursor_t TX_MAIN_DEFAULT = 7'd64;

    typedef struct packed {
        bus_addr_t adr;
        data_t     dat;
        logic      we;
        logic      stb;
        logic      cyc;
    } bus_req_t;

    typedef struct packed {
        data_t dat;
        logic  ack;
    } bus_rsp_t;

    typedef struct packed {
        drp_addr_t addr;
        data_t     dat;
        logic      en;
        logic      we;
    } drp_req_t;

    typedef struct packed {
        prbs_sel_t    prbs_sel;
        logic         inject;    // Toggle in clk domain, pulse at the lane.
        logic         polarity;
        logic         elecidle;
        logic         inhibit;
        swing_t       swing;
        main_cursor_t main;
        cursor_t      post;
        cursor_t      pre;
    } tx_cfg_t;

    typedef struct packed {
        logic      polarity;
        logic      cnt_reset;    // Toggle in clk domain, pulse at the lane.
        prbs_sel_t prbs_sel;
    } rx_cfg_t;

    typedef struct packed {
        logic lane;
        logic tx;
        logic rx;
    } lane_rst_t;

    localparam tx_cfg_t TX_CFG_RESET = '{
        swing:   TX_DIFF_DEFAULT,
        main:    TX_MAIN_DEFAULT,
        default: '0
    };

    typedef enum logic [1:0] {
        DRP_IDLE,
        DRP_WAIT,
        DRP_ACK
    } drp_state_t;

endpackage

`default_nettype wire

// File: hdl/gty_drp_bridge.sv
// Host bus to DRP bridge.
// Each access becomes one DRP enable pulse; ack follows the port's ready.
`timescale 1ns/1ns
`default_nettype none

module gty_drp_bridge
    import gty_ctrl_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     gty_rx_reset_reg,

    input  wire bus_req_t bus_req_i,
    output bus_rsp_t      bus_rsp_o,

    output drp_req_t      drp_req_o,
    input  wire data_t    drp_di_i,
    input  wire logic     drp_rdy_i
);

    drp_state_t state_q;
    logic       access;
    logic       en_q;
    logic       we_q;
    drp_addr_t  addr_q;
    data_t      wr_q;
    data_t      rd_q;
    logic       ack;

    assign access = bus_req_i.cyc && bus_req_i.stb;
    assign ack    = (state_q == DRP_ACK);

    always_ff @(posedge clk or posedge gty_rx_reset_reg) begin
        if (gty_rx_reset_reg) begin
            state_q <= DRP_IDLE;
            en_q    <= 1'b0;
            we_q    <= 1'b0;
        end else begin
            en_q <= 1'b0;
            we_q <= 1'b0;
            case (state_q)
                DRP_IDLE: begin
                    if (access) begin
                        en_q    <= 1'b1;
                        we_q    <= bus_req_i.we;
                        state_q <= DRP_WAIT;
                    end
                end
                DRP_WAIT: begin
                    if (drp_rdy_i) state_q <= DRP_ACK;
                end
                DRP_ACK: state_q <= DRP_IDLE;  // Host drops strobe here.
                default: state_q <= DRP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == DRP_IDLE && access) begin
            addr_q <= bus_req_i.adr[DRP_ADDR_W-1:0];
            wr_q   <= bus_req_i.dat;
        end
        if (state_q == DRP_WAIT && drp_rdy_i) rd_q <= drp_di_i;
    end

    assign drp_req_o = '{addr: addr_q, dat: wr_q, en: en_q, we: we_q};
    assign bus_rsp_o = '{dat: ack ? rd_q : '0, ack: ack};

endmodule

`default_nettype wire

// File: hdl/gty_reg_file.sv
// Local control and status registers of the lane.
// Write decode, read mux, reset pulses, PRBS toggles and a sticky
// PRBS error flag that clears on read.
`timescale 1ns/1ns
`default_nettype none

module gty_reg_file
    import gty_ctrl_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     gty_rx_reset_reg,

    input  wire bus_req_t bus_req_i,
    output bus_rsp_t      bus_rsp_o,

    output lane_rst_t     lane_rst_o,
    output tx_cfg_t       tx_cfg_o,
    output rx_cfg_t       rx_cfg_o,

    input  wire logic     tx_done_i,
    input  wire logic     rx_done_i,
    input  wire logic     prbs_err_i,
    input  wire logic     prbs_lock_i
);

    reg_idx_t  idx;
    logic      access;
    logic      wr;
    logic      rd;
    logic      ack_q;
    data_t     rd_data;
    data_t     rd_q;
    tx_cfg_t   tx_cfg_q;
    rx_cfg_t   rx_cfg_q;
    lane_rst_t rst_q;
    logic      err_q;
    logic      err_seen_q;
    logic      err_rise;

    assign idx      = bus_req_i.adr[7:0];
    assign access   = bus_req_i.cyc && bus_req_i.stb && !ack_q;  // One ack per request.
    assign wr       = access && bus_req_i.we;
    assign rd       = access && !bus_req_i.we;
    assign err_rise = prbs_err_i && !err_seen_q;

    always_comb begin
        rd_data = '0;
        case (idx)
            REG_RESET: begin
                rd_data[9]  = tx_done_i;
                rd_data[10] = rx_done_i;
            end
            REG_POLARITY: rd_data[1:0] = {rx_cfg_q.polarity, tx_cfg_q.polarity};
            REG_PRBS_SEL: rd_data[7:0] = {rx_cfg_q.prbs_sel, tx_cfg_q.prbs_sel};
            REG_PRBS_CTRL: begin
                rd_data[2] = err_q;
                rd_data[3] = prbs_lock_i;
            end
            REG_TX_IDLE: rd_data[1:0] = {tx_cfg_q.inhibit, tx_cfg_q.elecidle};
            REG_TX_DIFF: rd_data[4:0] = tx_cfg_q.swing;
            REG_TX_MAIN: rd_data[6:0] = tx_cfg_q.main;
            REG_TX_POST: rd_data[4:0] = tx_cfg_q.post;
            REG_TX_PRE:  rd_data[4:0] = tx_cfg_q.pre;
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge gty_rx_reset_reg) begin
        if (gty_rx_reset_reg) begin
            ack_q      <= 1'b0;
            rst_q      <= '0;
            tx_cfg_q   <= TX_CFG_RESET;
            rx_cfg_q   <= '0;
            err_q      <= 1'b0;
            err_seen_q <= 1'b0;
        end else begin
            ack_q      <= access;
            rst_q      <= '0;          // Pulses last one cycle.
            err_seen_q <= prbs_err_i;

            if (err_rise) begin
                err_q <= 1'b1;         // New error wins over the clear.
            end else if (rd && idx == REG_PRBS_CTRL) begin
                err_q <= 1'b0;
            end

            if (wr) begin
                case (idx)
                    REG_RESET: begin
                        rst_q.lane <= bus_req_i.dat[0];
                        rst_q.tx   <= bus_req_i.dat[1];
                        rst_q.rx   <= bus_req_i.dat[2];
                    end
                    REG_POLARITY: begin
                        tx_cfg_q.polarity <= bus_req_i.dat[0];
                        rx_cfg_q.polarity <= bus_req_i.dat[1];
                    end
                    REG_PRBS_SEL: begin
                        tx_cfg_q.prbs_sel <= bus_req_i.dat[3:0];
                        rx_cfg_q.prbs_sel <= bus_req_i.dat[7:4];
                    end
                    REG_PRBS_CTRL: begin
                        tx_cfg_q.inject    <= tx_cfg_q.inject ^ bus_req_i.dat[0];
                        rx_cfg_q.cnt_reset <= rx_cfg_q.cnt_reset ^ bus_req_i.dat[1];
                    end
                    REG_TX_IDLE: begin
                        tx_cfg_q.elecidle <= bus_req_i.dat[0];
                        tx_cfg_q.inhibit  <= bus_req_i.dat[1];
                    end
                    REG_TX_DIFF: tx_cfg_q.swing <= bus_req_i.dat[4:0];
                    REG_TX_MAIN: tx_cfg_q.main  <= bus_req_i.dat[6:0];
                    REG_TX_POST: tx_cfg_q.post  <= bus_req_i.dat[4:0];
                    REG_TX_PRE:  tx_cfg_q.pre   <= bus_req_i.dat[4:0];
                    default: ;
                endcase
            end
        end
    end

    // Zero outside the ack cycle so the top can OR responses.
    always_ff @(posedge clk) begin
        rd_q <= rd ? rd_data : '0;
    end

    assign bus_rsp_o  = '{dat: rd_q, ack: ack_q};
    assign lane_rst_o = rst_q;
    assign tx_cfg_o   = tx_cfg_q;
    assign rx_cfg_o   = rx_cfg_q;

endmodule

`default_nettype wire

// File: hdl/gty_rx_sync.sv
// RX user clock domain logic.
// Reset synchronizer, settings capture, counter-reset pulse, PRBS error
// stretching and lock/done return to the system clock.
`timescale 1ns/1ns
`default_nettype none

module gty_rx_sync
    import gty_ctrl_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    gty_rxusrclk2_i,
    input  wire logic    rx_rst_req_i,
    input  wire rx_cfg_t rx_cfg_i,
    output rx_cfg_t      rx_cfg_o,
    output logic         rx_reset_o,
    input  wire logic    rx_reset_done_i,
    input  wire logic    prbserr_i,
    input  wire logic    prbslocked_i,
    output logic         rx_done_o,
    output logic         prbs_err_o,
    output logic         prbs_lock_o
);

    logic [1:0] rst_sync;
    rx_cfg_t    cfg_meta;
    rx_cfg_t    cfg_sync;
    logic       cnt_reset_q;
    logic       err_hold = 1'b0;  // Power-up clear.
    logic       err_ret_meta;
    logic       err_ret;
    logic       lock_rx;
    logic       done_rx;
    logic [1:0] err_sync;
    logic [1:0] lock_sync;
    logic [1:0] done_sync;

    always_ff @(posedge gty_rxusrclk2_i or posedge rx_rst_req_i) begin
        if (rx_rst_req_i) begin
            rst_sync <= 2'b11;
        end else begin
            rst_sync <= {rst_sync[0], 1'b0};
        end
    end

    always_ff @(posedge gty_rxusrclk2_i) begin
        cfg_meta     <= rx_cfg_i;
        cfg_sync     <= cfg_meta;
        cnt_reset_q  <= cfg_sync.cnt_reset;
        // Held until the flag has reached clk and come back.
        err_hold     <= (err_hold && !err_ret) || prbserr_i;
        err_ret_meta <= err_sync[1];
        err_ret      <= err_ret_meta;
        lock_rx      <= prbslocked_i;
        done_rx      <= rx_reset_done_i;
    end

    always_ff @(posedge clk) begin
        err_sync  <= {err_sync[0], err_hold};
        lock_sync <= {lock_sync[0], lock_rx};
        done_sync <= {done_sync[0], done_rx};
    end

    always_comb begin
        rx_cfg_o           = cfg_sync;
        rx_cfg_o.cnt_reset = cfg_sync.cnt_reset ^ cnt_reset_q;
    end

    assign rx_reset_o  = rst_sync[1];
    assign prbs_err_o  = err_sync[1];
    assign prbs_lock_o = lock_sync[1];
    assign rx_done_o   = done_sync[1];

endmodule

`default_nettype wire

// File: hdl/gty_tx_sync.sv
// TX user clock domain logic.
// Reset synchronizer, settings capture, error-injection pulse and
// reset-done return to the system clock.
`timescale 1ns/1ns
`default_nettype none

module gty_tx_sync
    import gty_ctrl_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    gty_txusrclk2_i,
    input  wire logic    tx_rst_req_i,
    input  wire tx_cfg_t tx_cfg_i,
    output tx_cfg_t      tx_cfg_o,
    output logic         tx_reset_o,
    input  wire logic    tx_reset_done_i,
    output logic         tx_done_o
);

    logic [1:0] rst_sync;
    tx_cfg_t    cfg_meta;
    tx_cfg_t    cfg_sync;
    logic       inject_q;
    logic       done_tx;
    logic       done_meta;
    logic       done_sync;

    // Assert at once, release after two TX edges.
    always_ff @(posedge gty_txusrclk2_i or posedge tx_rst_req_i) begin
        if (tx_rst_req_i) begin
            rst_sync <= 2'b11;
        end else begin
            rst_sync <= {rst_sync[0], 1'b0};
        end
    end

    always_ff @(posedge gty_txusrclk2_i) begin
        cfg_meta <= tx_cfg_i;
        cfg_sync <= cfg_meta;
        inject_q <= cfg_sync.inject;  // Third stage of the toggle chain.
        done_tx  <= tx_reset_done_i;
    end

    always_ff @(posedge clk) begin
        done_meta <= done_tx;
        done_sync <= done_meta;
    end

    always_comb begin
        tx_cfg_o        = cfg_sync;
        tx_cfg_o.inject = cfg_sync.inject ^ inject_q;
    end

    assign tx_reset_o = rst_sync[1];
    assign tx_done_o  = done_sync;

endmodule

`default_nettype wire

// File: verif/gty_ctrl_cases.txt
# name op addr wdata expect, numbers in hex, addr bit 10 selects local registers
# ops: W write, R read, P poll read, T lane outputs, D done inputs, E rx error, X/I pulse counts
def_diff      R 405 0000 0010
def_main      R 406 0000 0040
def_ctrl      R 403 0000 0000
def_idle      R 404 0000 0000
def_lane_diff T 405 0000 0010
def_lane_main T 406 0000 0040
def_lane_pol  T 401 0000 0000
wr_pol        W 401 fffd 0000
rd_pol        R 401 0000 0001
lane_pol      T 401 0000 0001
wr_sel        W 402 a5c3 0000
rd_sel        R 402 0000 00c3
lane_sel      T 402 0000 00c3
wr_idle       W 404 0006 0000
rd_idle       R 404 0000 0002
lane_idle     T 404 0000 0002
wr_diff       W 405 ffea 0000
rd_diff       R 405 0000 000a
lane_diff     T 405 0000 000a
wr_main       W 406 00aa 0000
rd_main       R 406 0000 002a
lane_main     T 406 0000 002a
wr_post       W 407 0033 0000
rd_post       R 407 0000 0013
lane_post     T 407 0000 0013
wr_pre        W 408 0ffe 0000
rd_pre        R 408 0000 001e
lane_pre      T 408 0000 001e
wr_unmapped   W 410 ffff 0000
rd_unmapped   R 410 0000 0000
drp_wr_a      W 123 beef 0000
drp_wr_b      W 3ff 1234 0000
drp_rd_a      R 123 0000 beef
drp_rd_b      R 3ff 0000 1234
tx_rst        W 400 0002 0000
tx_rst_pulse  X 000 0000 0001
done_on       D 000 0003 0000
done_rd       P 400 0000 0600
err_pulse     E 000 0000 0000
err_set       P 403 0000 0004
err_clear     R 403 0000 0000
inject_a      W 403 0001 0000
inject_a_cnt  I 000 0000 0001
inject_b      W 403 0001 0000
inject_b_cnt  I 000 0000 0002

// File: verif/gty_ctrl_chk.sv
// Protocol checker for the lane control top.
// Bus acknowledge and DRP enable rules, bound into gty_ctrl.
`timescale 1ns/1ns
`default_nettype none

module gty_ctrl_chk
    import gty_ctrl_pkg::*;
(
    input wire logic     clk,
    input wire logic     gty_rx_reset_reg,
    input wire bus_req_t bus_req_i,
    input wire bus_rsp_t bus_rsp_i,
    input wire drp_req_t drp_req_i
);

    logic local_req;
    int   fail_cnt = 0;  // Failed assertions so far.

    assign local_req = bus_req_i.cyc && bus_req_i.stb && bus_req_i.adr[BUS_ADDR_W-1];

    ack_single: assert property (@(posedge clk) disable iff (gty_rx_reset_reg)
        bus_rsp_i.ack |=> !bus_rsp_i.ack)
        else begin
            $error("Bus ack high for two cycles in a row");
            fail_cnt++;
        end

    drp_en_single: assert property (@(posedge clk) disable iff (gty_rx_reset_reg)
        drp_req_i.en |=> !drp_req_i.en)
        else begin
            $error("DRP enable held longer than one cycle");
            fail_cnt++;
        end

    // Local accesses never touch the DRP.
    drp_quiet_local: assert property (@(posedge clk) disable iff (gty_rx_reset_reg)
        local_req |-> !drp_req_i.en)
        else begin
            $error("DRP enable seen during a local register access");
            fail_cnt++;
        end

    local_ack_latency: assert property (@(posedge clk) disable iff (gty_rx_reset_reg)
        $rose(local_req) |=> bus_rsp_i.ack)
        else begin
            $error("Local register access not acknowledged after one cycle");
            fail_cnt++;
        end

endmodule

bind gty_ctrl gty_ctrl_chk u_chk (
    .clk              (clk),
    .gty_rx_reset_reg (gty_rx_reset_reg),
    .bus_req_i        (bus_req_i),
    .bus_rsp_i        (bus_rsp_o),
    .drp_req_i        (drp_req_o)
);

`default_nettype wire

// File: verif/gty_ctrl_clk_gen.sv
// Clock and reset generator for the lane control testbench.
// System clock, both transceiver user clocks and the power-on reset.
`timescale 1ns/1ns
`default_nettype none

module gty_ctrl_clk_gen (
    output logic clk,
    output logic txusrclk2_o,
    output logic rxusrclk2_o,
    output logic gty_rx_reset_reg
);

    localparam int CLK_HALF     = 10;
    localparam int TX_HALF      = 8;
    localparam int RX_HALF      = 12;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk              = 1'b0;
        txusrclk2_o      = 1'b0;
        rxusrclk2_o      = 1'b0;
        gty_rx_reset_reg = 1'b1;
        #(RESET_CYCLES * 2 * CLK_HALF);
        gty_rx_reset_reg = 1'b0;  // Lands on a falling clk edge.
    end

    always #(CLK_HALF) clk = ~clk;
    always #(TX_HALF) txusrclk2_o = ~txusrclk2_o;
    always #(RX_HALF) rxusrclk2_o = ~rxusrclk2_o;

endmodule

`default_nettype wire

// File: verif/gty_ctrl_tb.sv
// Testbench for the transceiver lane control block.
// Runs the accesses of the case file, models the DRP port and lane status,
// and checks read data and lane outputs.
`timescale 1ns/1ns
`default_nettype none

module gty_ctrl_tb
    import gty_ctrl_pkg::*;
();

    localparam int          ACK_TIMEOUT  = 64;
    localparam int          POLL_LIMIT   = 32;
    localparam int          LANE_TIMEOUT = 64;
    localparam int          GUARD_CYCLES = 16;
    localparam logic [31:0] LFSR_SEED    = 32'hd147_2cb8;

    logic      clk;
    logic      tx_clk;
    logic      rx_clk;
    logic      gty_rx_reset_reg;
    bus_req_t  bus_req;
    bus_rsp_t  bus_rsp;
    drp_req_t  drp_req;
    data_t     drp_di;
    logic      drp_rdy;
    logic      gty_reset;
    logic      tx_reset;
    logic      rx_reset;
    logic      tx_done_in;
    logic      rx_done_in;
    tx_cfg_t   tx_cfg;
    rx_cfg_t   rx_cfg;
    logic      prbs_err_in;
    logic      prbs_lock_in;
    int        inject_cnt = 0;
    int        tx_rst_rises = 0;
    int        rx_rst_rises = 0;
    int        lane_rst_rises = 0;
    int        rx_rst_exp = 0;
    int        lane_rst_exp = 0;
    data_t     drp_mem [0:(1 << DRP_ADDR_W) - 1];
    drp_addr_t drp_addr_l;
    int        drp_wait = 0;
    logic [31:0] lfsr = LFSR_SEED;

    gty_ctrl_clk_gen u_clk_gen (
        .clk              (clk),
        .txusrclk2_o      (tx_clk),
        .rxusrclk2_o      (rx_clk),
        .gty_rx_reset_reg (gty_rx_reset_reg)
    );

    gty_ctrl UUT (
        .clk                 (clk),
        .gty_rx_reset_reg    (gty_rx_reset_reg),
        .bus_req_i           (bus_req),
        .bus_rsp_o           (bus_rsp),
        .drp_req_o           (drp_req),
        .drp_di_i            (drp_di),
        .drp_rdy_i           (drp_rdy),
        .gty_reset_o         (gty_reset),
        .gty_tx_reset_o      (tx_reset),
        .gty_rx_reset_o      (rx_reset),
        .gty_tx_reset_done_i (tx_done_in),
        .gty_rx_reset_done_i (rx_done_in),
        .gty_txusrclk2_i     (tx_clk),
        .gty_rxusrclk2_i     (rx_clk),
        .gty_tx_cfg_o        (tx_cfg),
        .gty_rx_cfg_o        (rx_cfg),
        .gty_rxprbserr_i     (prbs_err_in),
        .gty_rxprbslocked_i  (prbs_lock_in)
    );

    task automatic fail_run();
        $display("Regression failed");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic report_mismatch(input string name, input data_t exp, input data_t act);
        $display("** Error %s: expected %h, actual %h", name, exp, act);
        fail_run();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        fail_run();
    endtask

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Register map view of the lane side outputs.
    function automatic data_t lane_view(input reg_idx_t idx, input tx_cfg_t tx,
                                        input rx_cfg_t rx);
        data_t v;
        v = '0;
        case (idx)
            REG_POLARITY: v[1:0] = {rx.polarity, tx.polarity};
            REG_PRBS_SEL: v[7:0] = {rx.prbs_sel, tx.prbs_sel};
            REG_TX_IDLE:  v[1:0] = {tx.inhibit, tx.elecidle};
            REG_TX_DIFF:  v[4:0] = tx.swing;
            REG_TX_MAIN:  v[6:0] = tx.main;
            REG_TX_POST:  v[4:0] = tx.post;
            REG_TX_PRE:   v[4:0] = tx.pre;
            default: ;
        endcase
        return v;
    endfunction

    initial begin
        for (int a = 0; a < (1 << DRP_ADDR_W); a++) begin
            drp_mem[a] = data_t'(a) ^ 16'h5a3c;
        end
    end

    // DRP port model, ready after 1 to 8 cycles.
    always @(negedge clk) begin : drp_model
        logic [2:0] delay;
        drp_rdy = 1'b0;
        if (drp_wait > 0) begin
            drp_wait = drp_wait - 1;
            if (drp_wait == 0) begin
                drp_rdy = 1'b1;
                drp_di  = drp_mem[drp_addr_l];
            end
        end
        if (drp_req.en === 1'b1) begin
            assert (drp_req.addr == bus_req.adr[DRP_ADDR_W-1:0])
                else report_mismatch("drp_addr", data_t'(bus_req.adr[DRP_ADDR_W-1:0]),
                                     data_t'(drp_req.addr));
            assert (drp_req.we == bus_req.we)
                else report_problem("DRP write enable differs from the bus write enable");
            if (drp_req.we) drp_mem[drp_req.addr] = drp_req.dat;
            drp_addr_l = drp_req.addr;
            delay = '0;
            for (int k = 0; k < 3; k++) begin
                lfsr  = lfsr_next(lfsr);
                delay = {delay[1:0], lfsr[0]};
            end
            drp_wait = int'(delay) + 1;
        end
    end

    always @(negedge tx_clk) begin
        if (!gty_rx_reset_reg && tx_cfg.inject === 1'b1) inject_cnt++;
    end

    always @(posedge tx_reset) begin
        if (!gty_rx_reset_reg) tx_rst_rises++;
    end

    always @(posedge rx_reset) begin
        if (!gty_rx_reset_reg) rx_rst_rises++;
    end

    always @(posedge gty_reset) begin
        if (!gty_rx_reset_reg) lane_rst_rises++;
    end

    always @(UUT.u_chk.fail_cnt) begin
        assert (UUT.u_chk.fail_cnt == 0)
            else report_problem("A bus or DRP protocol assertion failed");
    end

    task automatic bus_access(input string name, input bus_addr_t adr, input logic we,
                              input data_t wdat, output data_t rdat);
        int n;
        @(negedge clk);
        bus_req = '{adr: adr, dat: wdat, we: we, stb: 1'b1, cyc: 1'b1};
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (bus_rsp.ack !== 1'b1 && n < ACK_TIMEOUT);
        assert (bus_rsp.ack === 1'b1)
            else report_problem($sformatf("Case %s got no bus ack in time", name));
        rdat    = bus_rsp.dat;
        bus_req = '0;
    endtask

    task automatic run_case(input string name, input string op, input bus_addr_t adr,
                            input data_t wdat, input data_t exp);
        data_t rdat;
        int    n;
        n = 0;
        case (op)
            "W": begin
                bus_access(name, adr, 1'b1, wdat, rdat);
                // Lane and RX reset pulses due from writes to REG_RESET.
                if (adr[BUS_ADDR_W-1] && adr[7:0] == REG_RESET) begin
                    lane_rst_exp += int'(wdat[0]);
                    rx_rst_exp   += int'(wdat[2]);
                end
            end
            "R": begin
                bus_access(name, adr, 1'b0, '0, rdat);
                assert (rdat === exp) else report_mismatch(name, exp, rdat);
            end
            "P": begin
                bus_access(name, adr, 1'b0, '0, rdat);
                while (rdat !== exp && n < POLL_LIMIT) begin
                    bus_access(name, adr, 1'b0, '0, rdat);
                    n++;
                end
                assert (rdat === exp) else report_mismatch(name, exp, rdat);
            end
            "T": begin
                @(negedge tx_clk);
                while (lane_view(adr[7:0], tx_cfg, rx_cfg) !== exp && n < LANE_TIMEOUT) begin
                    @(negedge tx_clk);
                    n++;
                end
                rdat = lane_view(adr[7:0], tx_cfg, rx_cfg);
                assert (rdat === exp) else report_mismatch(name, exp, rdat);
            end
            "D": begin
                @(negedge clk);
                tx_done_in = wdat[0];
                rx_done_in = wdat[1];
            end
            "E": begin
                @(negedge rx_clk);
                prbs_err_in = 1'b1;
                @(negedge rx_clk);
                prbs_err_in = 1'b0;
            end
            "X": begin
                while ((tx_rst_rises != exp || lane_rst_rises != lane_rst_exp
                        || rx_rst_rises != rx_rst_exp
                        || {gty_reset, tx_reset, rx_reset} !== 3'b000)
                       && n < LANE_TIMEOUT) begin
                    @(negedge tx_clk);
                    n++;
                end
                assert (tx_rst_rises == exp)
                    else report_mismatch(name, exp, data_t'(tx_rst_rises));
                assert (lane_rst_rises == lane_rst_exp)
                    else report_mismatch({name, "_lane"}, data_t'(lane_rst_exp),
                                         data_t'(lane_rst_rises));
                assert (rx_rst_rises == rx_rst_exp)
                    else report_mismatch({name, "_rx"}, data_t'(rx_rst_exp),
                                         data_t'(rx_rst_rises));
                assert ({gty_reset, tx_reset, rx_reset} === 3'b000)
                    else report_problem($sformatf("Case %s: a lane reset never released", name));
            end
            "I": begin
                while (inject_cnt < exp && n < LANE_TIMEOUT) begin
                    @(negedge tx_clk);
                    n++;
                end
                repeat (GUARD_CYCLES) @(negedge tx_clk);  // Catch a stray second pulse.
                assert (inject_cnt == exp) else report_mismatch(name, exp, data_t'(inject_cnt));
            end
            default: report_problem($sformatf("Case %s has unknown operation %s", name, op));
        endcase
    endtask

    initial begin : main
        int        fd;
        int        fields;
        int        n;
        int        cases;
        string     line;
        string     name;
        string     op;
        bus_addr_t adr;
        data_t     wdat;
        data_t     exp;
        bus_req      = '0;
        drp_di       = '0;
        drp_rdy      = 1'b0;
        tx_done_in   = 1'b0;
        rx_done_in   = 1'b0;
        prbs_err_in  = 1'b0;
        prbs_lock_in = 1'b0;
        cases        = 0;
        n            = 0;
        @(negedge clk);
        while (gty_rx_reset_reg !== 1'b0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        assert (gty_rx_reset_reg === 1'b0) else report_problem("Reset was never released");
        assert ({bus_rsp.ack, drp_req.en, drp_req.we, gty_reset, tx_reset, rx_reset,
                 tx_cfg.inject, rx_cfg.cnt_reset} === 8'h00)
            else report_problem("Ack, DRP enable or a lane pulse output not low after reset");
        fd = $fopen("verif/gty_ctrl_cases.txt", "r");
        assert (fd != 0) else report_problem("Cannot open the case file");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") continue;
            fields = $sscanf(line, "%s %s %h %h %h", name, op, adr, wdat, exp);
            assert (fields == 5) else report_problem($sformatf("Malformed case line: %s", line));
            run_case(name, op, adr, wdat, exp);
            cases++;
        end
        $fclose(fd);
        $display("Ran %0d cases", cases);
        if (UUT.u_chk.fail_cnt == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            fail_run();
        end
    end

endmodule

`default_nettype wire
